//--- common/thor_dec_defines.svh
// ===============================================
// Thor decode stage definitions
// Opcode and function codes, instruction field
// positions and access-size codes
// ===============================================
`ifndef THOR_DEC_DEFINES_SVH
`define THOR_DEC_DEFINES_SVH

// Primary opcodes
`define THOR_OP_BRK    8'h00
`define THOR_OP_R2     8'h02
`define THOR_OP_ADDI   8'h04
`define THOR_OP_MULI   8'h06
`define THOR_OP_DIVI   8'h07
`define THOR_OP_ANDI   8'h08
`define THOR_OP_ORI    8'h09
`define THOR_OP_ADDIL  8'h14
`define THOR_OP_ANDIL  8'h18
`define THOR_OP_JMP    8'h20
`define THOR_OP_DJMP   8'h21
`define THOR_OP_JEQ    8'h26
`define THOR_OP_JNE    8'h27
`define THOR_OP_JLT    8'h28
`define THOR_OP_RTS    8'h2F
`define THOR_OP_EXI8   8'h50
`define THOR_OP_EXI24  8'h52
`define THOR_OP_EXI40  8'h54
`define THOR_OP_LDB    8'h80
`define THOR_OP_LDBU   8'h81
`define THOR_OP_LDW    8'h82
`define THOR_OP_LDO    8'h86
`define THOR_OP_LDBX   8'h90
`define THOR_OP_LDOX   8'h96
`define THOR_OP_STB    8'hA0
`define THOR_OP_STW    8'hA1
`define THOR_OP_STO    8'hA3
`define THOR_OP_STBX   8'hB0
`define THOR_OP_STOX   8'hB3
`define THOR_OP_NOP    8'hF1

// R2 function codes
`define THOR_FN_ADD    6'h04
`define THOR_FN_MUL    6'h08
`define THOR_FN_MULU   6'h09
`define THOR_FN_DIV    6'h10
`define THOR_FN_DIVU   6'h11

// Access sizes
`define THOR_SZ_BYTE   3'd0
`define THOR_SZ_WYDE   3'd1
`define THOR_SZ_OCTA   3'd3

`define THOR_LK_DEPTH_BASE  4'd8
`define THOR_DJMP_REG       5'd26

// ===============================================
// Field positions within the instruction word
// ===============================================
`define THOR_F_OP      7:0
`define THOR_F_RT      13:9
`define THOR_F_RA      18:14
`define THOR_F_RB      23:19
`define THOR_F_RC      28:24
`define THOR_F_FUNC    47:42
`define THOR_F_SIMM    31:19
`define THOR_SIMM_W    13
`define THOR_F_LIMM    47:19
`define THOR_LIMM_W    29
`define THOR_F_RS      13:9
`define THOR_F_LK      10:9
`define THOR_F_LKRD    13:11
`define THOR_F_BTGT    47:24
`define THOR_BTGT_W    24
`define THOR_F_JTGT    47:14
`define THOR_JTGT_W    34

// Prefix payloads and the immediate bits they keep
`define THOR_F_X8      15:8
`define THOR_F_X24     31:8
`define THOR_F_X40     47:8
`define THOR_IMM_KEEP  23:0

`endif

//--- common/thor_dec_pkg.sv
// ===============================================
// Thor decode package
// Vector types shared by the decode stage
// ===============================================
`default_nettype none

package thor_dec_pkg;

	// Instruction or prefix word
	typedef logic [63:0] instr_t;

	// Immediate or branch target
	typedef logic [63:0] value_t;

	typedef logic [7:0] opcode_t;
	typedef logic [5:0] func_t;

	// General register number
	typedef logic [4:0] regno_t;

	// Link register number
	typedef logic [3:0] lkno_t;

	// Access-size code
	typedef logic [2:0] memsz_t;

endpackage

`default_nettype wire

//--- decoder/thor_dec_regsel.sv
// ===============================================
// Thor register specifier selection
// Picks Ra, Rb, Rc and Rt from the instruction and
// detects a register-file write
// ===============================================
`timescale 1ns/1ps
`default_nettype none

`include "thor_dec_defines.svh"

module thor_dec_regsel (
	input  wire thor_dec_pkg::instr_t ir,
	output thor_dec_pkg::regno_t ra,
	output thor_dec_pkg::regno_t rb,
	output thor_dec_pkg::regno_t rc,
	output thor_dec_pkg::regno_t rt,
	output logic rfwr
);

	thor_dec_pkg::opcode_t opcode;

	assign opcode = ir[`THOR_F_OP];
	assign rb = ir[`THOR_F_RB];

	always_comb
	begin
		// DJMP reads its target from the fixed jump register
		case (opcode)
			`THOR_OP_DJMP: ra = `THOR_DJMP_REG;
			default:       ra = ir[`THOR_F_RA];
		endcase

		// No target for stores, branches and prefixes
		case (opcode)
			`THOR_OP_STB, `THOR_OP_STW, `THOR_OP_STO,
			`THOR_OP_STBX, `THOR_OP_STOX,
			`THOR_OP_JEQ, `THOR_OP_JNE, `THOR_OP_JLT, `THOR_OP_JMP,
			`THOR_OP_EXI8, `THOR_OP_EXI24, `THOR_OP_EXI40:
				rt = '0;
			`THOR_OP_DJMP:
				rt = `THOR_DJMP_REG;
			default:
				rt = ir[`THOR_F_RT];
		endcase

		// Stores carry the data register in the Rt slot
		case (opcode)
			`THOR_OP_STB, `THOR_OP_STW, `THOR_OP_STO,
			`THOR_OP_STBX, `THOR_OP_STOX:
				rc = ir[`THOR_F_RS];
			default:
				rc = ir[`THOR_F_RC];
		endcase

		case (opcode)
			`THOR_OP_R2,
			`THOR_OP_ADDI, `THOR_OP_ANDI, `THOR_OP_ORI, `THOR_OP_MULI, `THOR_OP_DIVI,
			`THOR_OP_ADDIL, `THOR_OP_ANDIL,
			`THOR_OP_LDB, `THOR_OP_LDBU, `THOR_OP_LDW, `THOR_OP_LDO,
			`THOR_OP_LDBX, `THOR_OP_LDOX,
			`THOR_OP_DJMP:
				rfwr = 1'b1;
			default:
				rfwr = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- decoder/thor_dec_imm.sv
// ===============================================
// Thor immediate builder
// Extracts and extends the instruction immediate
// and merges an EXI8, EXI24 or EXI40 prefix
// ===============================================
`timescale 1ns/1ps
`default_nettype none

`include "thor_dec_defines.svh"

module thor_dec_imm (
	input  wire thor_dec_pkg::instr_t ir,
	input  wire thor_dec_pkg::instr_t xir,
	input  wire logic xval,
	output thor_dec_pkg::value_t imm
);

	localparam int XLEN = $bits(thor_dec_pkg::value_t);
	localparam int KEEP_W = 24;

	thor_dec_pkg::opcode_t opcode;
	thor_dec_pkg::value_t base;
	logic [`THOR_SIMM_W-1:0] simm;
	logic [`THOR_LIMM_W-1:0] limm;
	logic [7:0] x8;
	logic [23:0] x24;
	logic [39:0] x40;

	assign opcode = ir[`THOR_F_OP];
	assign simm = ir[`THOR_F_SIMM];
	assign limm = ir[`THOR_F_LIMM];
	assign x8 = xir[`THOR_F_X8];
	assign x24 = xir[`THOR_F_X24];
	assign x40 = xir[`THOR_F_X40];

	// Immediate as encoded in the instruction itself
	always_comb
	begin
		case (opcode)
			`THOR_OP_ADDI, `THOR_OP_MULI, `THOR_OP_DIVI:
				base = {{(XLEN - `THOR_SIMM_W){simm[`THOR_SIMM_W-1]}}, simm};
			`THOR_OP_ANDI:
				base = {{(XLEN - `THOR_SIMM_W){1'b1}}, simm};
			`THOR_OP_ORI:
				base = {{(XLEN - `THOR_SIMM_W){1'b0}}, simm};
			// Displacement shares the long immediate field
			`THOR_OP_ADDIL,
			`THOR_OP_LDB, `THOR_OP_LDBU, `THOR_OP_LDW, `THOR_OP_LDO,
			`THOR_OP_STB, `THOR_OP_STW, `THOR_OP_STO:
				base = {{(XLEN - `THOR_LIMM_W){limm[`THOR_LIMM_W-1]}}, limm};
			`THOR_OP_ANDIL:
				base = {{(XLEN - `THOR_LIMM_W){1'b1}}, limm};
			default:
				base = '0;
		endcase
	end

	// Prefix supplies everything above bit 23
	always_comb
	begin
		imm = base;
		if (xval)
		begin
			case (xir[`THOR_F_OP])
				`THOR_OP_EXI8:
					imm = {{(XLEN - KEEP_W - 8){x8[7]}}, x8, base[`THOR_IMM_KEEP]};
				`THOR_OP_EXI24:
					imm = {{(XLEN - KEEP_W - 24){x24[23]}}, x24, base[`THOR_IMM_KEEP]};
				`THOR_OP_EXI40:
					imm = {x40, base[`THOR_IMM_KEEP]};
				default:
					imm = base;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- decoder/thor_dec_class.sv
// ===============================================
// Thor operation classifier
// Load, store and access size, multiply and divide
// variants, conditional branches and multi-cycle
// detection
// ===============================================
`timescale 1ns/1ps
`default_nettype none

`include "thor_dec_defines.svh"

module thor_dec_class (
	input  wire thor_dec_pkg::instr_t ir,
	output logic ld,
	output logic ldz,
	output logic st,
	output logic mem_indexed,
	output thor_dec_pkg::memsz_t memsz,
	output logic mul,
	output logic mulu,
	output logic muli,
	output logic div,
	output logic divu,
	output logic divi,
	output logic mulall,
	output logic divall,
	output logic is_jxx,
	output logic multi_cycle
);

	thor_dec_pkg::opcode_t opcode;
	thor_dec_pkg::func_t func;
	logic is_r2;

	assign opcode = ir[`THOR_F_OP];
	assign func = ir[`THOR_F_FUNC];
	assign is_r2 = (opcode == `THOR_OP_R2);

	// ===============================================
	// Memory operations
	// ===============================================
	always_comb
	begin
		ld = 1'b0;
		st = 1'b0;
		mem_indexed = 1'b0;
		memsz = `THOR_SZ_OCTA;
		case (opcode)
			`THOR_OP_LDB, `THOR_OP_LDBU, `THOR_OP_LDW, `THOR_OP_LDO:
				ld = 1'b1;
			`THOR_OP_LDBX, `THOR_OP_LDOX:
			begin
				ld = 1'b1;
				mem_indexed = 1'b1;
			end
			`THOR_OP_STB, `THOR_OP_STW, `THOR_OP_STO:
				st = 1'b1;
			`THOR_OP_STBX, `THOR_OP_STOX:
			begin
				st = 1'b1;
				mem_indexed = 1'b1;
			end
			default:
				ld = 1'b0;
		endcase

		case (opcode)
			`THOR_OP_LDB, `THOR_OP_LDBU, `THOR_OP_LDBX, `THOR_OP_STB, `THOR_OP_STBX:
				memsz = `THOR_SZ_BYTE;
			`THOR_OP_LDW, `THOR_OP_STW:
				memsz = `THOR_SZ_WYDE;
			default:
				memsz = `THOR_SZ_OCTA;
		endcase
	end

	// Only the byte load zero-extends
	assign ldz = (opcode == `THOR_OP_LDBU);

	// ===============================================
	// Multiply and divide
	// ===============================================
	assign mul  = is_r2 && (func == `THOR_FN_MUL);
	assign mulu = is_r2 && (func == `THOR_FN_MULU);
	assign muli = (opcode == `THOR_OP_MULI);
	assign div  = is_r2 && (func == `THOR_FN_DIV);
	assign divu = is_r2 && (func == `THOR_FN_DIVU);
	assign divi = (opcode == `THOR_OP_DIVI);

	assign mulall = mul | mulu | muli;
	assign divall = div | divu | divi;

	assign is_jxx = (opcode == `THOR_OP_JEQ) || (opcode == `THOR_OP_JNE) ||
		(opcode == `THOR_OP_JLT);

	// Memory and multiply/divide units take more than one cycle
	assign multi_cycle = ld | st | mulall | divall;

endmodule

`default_nettype wire

//--- decoder/thor_dec_flow.sv
// ===============================================
// Thor flow-control decode
// Jump and branch flags, jump target and link
// register read and write selection
// ===============================================
`timescale 1ns/1ps
`default_nettype none

`include "thor_dec_defines.svh"

module thor_dec_flow (
	input  wire thor_dec_pkg::instr_t ir,
	input  wire logic is_jxx,
	output logic jmp,
	output logic dj,
	output logic rts,
	output logic flowchg,
	output logic lk_wr,
	output thor_dec_pkg::value_t jmptgt,
	output thor_dec_pkg::lkno_t lk_rd,
	output thor_dec_pkg::lkno_t lk_sel
);

	localparam int XLEN = $bits(thor_dec_pkg::value_t);

	thor_dec_pkg::opcode_t opcode;
	thor_dec_pkg::lkno_t lk_num;
	logic [`THOR_BTGT_W-1:0] btgt;
	logic [`THOR_JTGT_W-1:0] jtgt;

	assign opcode = ir[`THOR_F_OP];
	assign btgt = ir[`THOR_F_BTGT];
	assign jtgt = ir[`THOR_F_JTGT];
	assign lk_num = {2'b00, ir[`THOR_F_LK]};

	assign jmp = (opcode == `THOR_OP_JMP) || (opcode == `THOR_OP_DJMP);
	assign dj = (opcode == `THOR_OP_DJMP);
	assign rts = (opcode == `THOR_OP_RTS);
	assign flowchg = jmp | is_jxx | rts;

	// Targets are wyde aligned, hence the shift by one
	assign jmptgt = is_jxx ?
		{{(XLEN - `THOR_BTGT_W - 1){btgt[`THOR_BTGT_W-1]}}, btgt, 1'b0} :
		{{(XLEN - `THOR_JTGT_W - 1){jtgt[`THOR_JTGT_W-1]}}, jtgt, 1'b0};

	always_comb
	begin
		if (is_jxx || jmp)
			lk_rd = {1'b0, ir[`THOR_F_LKRD]};
		else if (rts)
			lk_rd = lk_num;
		else
			lk_rd = '0;

		// Link 0 is never written by a branch
		if (opcode == `THOR_OP_BRK)
		begin
			lk_sel = `THOR_LK_DEPTH_BASE;
			lk_wr = 1'b1;
		end
		else if (is_jxx || jmp)
		begin
			lk_sel = lk_num;
			lk_wr = (lk_num != '0);
		end
		else
		begin
			lk_sel = '0;
			lk_wr = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/thor_dec_stage.sv
// ===============================================
// Thor decode stage
// Runs the decode modules in parallel and registers
// their results for the next pipeline stage
// ===============================================
`timescale 1ns/1ps
`default_nettype none

module thor_dec_stage (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic in_valid,
	input  wire thor_dec_pkg::instr_t ir,
	input  wire thor_dec_pkg::instr_t xir,
	input  wire logic xval,
	output logic out_valid,
	output thor_dec_pkg::regno_t ra,
	output thor_dec_pkg::regno_t rb,
	output thor_dec_pkg::regno_t rc,
	output thor_dec_pkg::regno_t rt,
	output logic rfwr,
	output thor_dec_pkg::value_t imm,
	output thor_dec_pkg::value_t jmptgt,
	output logic ld,
	output logic ldz,
	output logic st,
	output thor_dec_pkg::memsz_t memsz,
	output logic mul,
	output logic mulu,
	output logic muli,
	output logic div,
	output logic divu,
	output logic divi,
	output logic mulall,
	output logic divall,
	output logic multi_cycle,
	output logic jmp,
	output logic is_jxx,
	output logic dj,
	output logic rts,
	output logic flowchg,
	output logic lk_wr,
	output thor_dec_pkg::lkno_t lk_rd,
	output thor_dec_pkg::lkno_t lk_sel
);

	// Total width of all registered decode fields
	localparam int DEC_W = 178;

	thor_dec_pkg::regno_t d_ra, d_rb, d_rc, d_rt;
	thor_dec_pkg::value_t d_imm, d_jmptgt;
	thor_dec_pkg::memsz_t d_memsz;
	thor_dec_pkg::lkno_t d_lk_rd, d_lk_sel;
	logic d_rfwr, d_ld, d_ldz, d_st;
	logic d_mul, d_mulu, d_muli, d_div, d_divu, d_divi, d_mulall, d_divall;
	logic d_multi_cycle, d_jmp, d_is_jxx, d_dj, d_rts, d_flowchg, d_lk_wr;
	logic [DEC_W-1:0] dec_d;
	logic [DEC_W-1:0] dec_q;

	thor_dec_regsel i_regsel (
		.ir   (ir),
		.ra   (d_ra),
		.rb   (d_rb),
		.rc   (d_rc),
		.rt   (d_rt),
		.rfwr (d_rfwr)
	);

	thor_dec_imm i_imm (
		.ir   (ir),
		.xir  (xir),
		.xval (xval),
		.imm  (d_imm)
	);

	// Indexed flag is not carried past decode
	thor_dec_class i_class (
		.ir          (ir),
		.ld          (d_ld),
		.ldz         (d_ldz),
		.st          (d_st),
		.mem_indexed (),
		.memsz       (d_memsz),
		.mul         (d_mul),
		.mulu        (d_mulu),
		.muli        (d_muli),
		.div         (d_div),
		.divu        (d_divu),
		.divi        (d_divi),
		.mulall      (d_mulall),
		.divall      (d_divall),
		.is_jxx      (d_is_jxx),
		.multi_cycle (d_multi_cycle)
	);

	thor_dec_flow i_flow (
		.ir      (ir),
		.is_jxx  (d_is_jxx),
		.jmp     (d_jmp),
		.dj      (d_dj),
		.rts     (d_rts),
		.flowchg (d_flowchg),
		.lk_wr   (d_lk_wr),
		.jmptgt  (d_jmptgt),
		.lk_rd   (d_lk_rd),
		.lk_sel  (d_lk_sel)
	);

	// ===============================================
	// Output register stage
	// ===============================================
	assign dec_d = {d_ra, d_rb, d_rc, d_rt, d_rfwr, d_imm, d_jmptgt,
		d_ld, d_ldz, d_st, d_memsz,
		d_mul, d_mulu, d_muli, d_div, d_divu, d_divi, d_mulall, d_divall,
		d_multi_cycle, d_jmp, d_is_jxx, d_dj, d_rts, d_flowchg, d_lk_wr,
		d_lk_rd, d_lk_sel};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Holds the last decoded instruction between valid cycles
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			dec_q <= '0;
		else if (in_valid)
			dec_q <= dec_d;
	end

	assign {ra, rb, rc, rt, rfwr, imm, jmptgt,
		ld, ldz, st, memsz,
		mul, mulu, muli, div, divu, divi, mulall, divall,
		multi_cycle, jmp, is_jxx, dj, rts, flowchg, lk_wr,
		lk_rd, lk_sel} = dec_q;

endmodule

`default_nettype wire

//--- sim/thor_dec_sva.sv
// ===============================================
// Thor decode stage assertions
// Valid timing and load/store exclusivity
// ===============================================
`timescale 1ns/1ps
`default_nettype none

module thor_dec_sva (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_valid,
	input wire logic out_valid,
	input wire logic ld,
	input wire logic st
);

	int fail_count = 0;

	reset_valid_low: assert property (@(posedge clk) !arst_n |-> !out_valid)
	else
	begin
		fail_count++;
		$error("out_valid high while in reset");
	end

	// One cycle from in_valid to out_valid
	valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) |-> (out_valid == $past(in_valid)))
	else
	begin
		fail_count++;
		$error("out_valid does not follow in_valid by one cycle");
	end

	ld_st_exclusive: assert property (@(posedge clk) !(ld && st))
	else
	begin
		fail_count++;
		$error("ld and st both high");
	end

endmodule

`default_nettype wire

//--- sim/thor_dec_tb.sv
// ===============================================
// Thor decode stage testbench
// Directed tests for valid timing, register
// selection, immediates, classification and
// flow-control decode
// ===============================================
`timescale 1ns/1ps
`default_nettype none

`include "thor_dec_defines.svh"

module thor_dec_tb;

	localparam int RESET_CYCLES = 5;
	localparam int TIMEOUT = 20;

	logic clk;
	logic arst_n;
	logic in_valid;
	thor_dec_pkg::instr_t ir;
	thor_dec_pkg::instr_t xir;
	logic xval;
	logic out_valid;
	thor_dec_pkg::regno_t ra, rb, rc, rt;
	logic rfwr;
	thor_dec_pkg::value_t imm, jmptgt;
	logic ld, ldz, st;
	thor_dec_pkg::memsz_t memsz;
	logic mul, mulu, muli, div, divu, divi, mulall, divall, multi_cycle;
	logic jmp, is_jxx, dj, rts, flowchg, lk_wr;
	thor_dec_pkg::lkno_t lk_rd, lk_sel;

	integer seed;
	string test_name;

	thor_dec_stage i_dut (.*);

	bind thor_dec_stage thor_dec_sva i_sva (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.ld        (ld),
		.st        (st)
	);

	always #10 clk = ~clk;

	// ===============================================
	// Helpers
	// ===============================================
	task automatic stop_run();
		$display("=== FAIL ===");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what,
				expected, actual);
			stop_run();
		end
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [63:0] sext(input logic [63:0] v, input int w);
		logic [63:0] s;
		s = v << (64 - w);
		return $signed(s) >>> (64 - w);
	endfunction

	function automatic thor_dec_pkg::instr_t op_word(input logic [7:0] op);
		thor_dec_pkg::instr_t w;
		w = {$random(seed), $random(seed)};
		w[`THOR_F_OP] = op;
		return w;
	endfunction

	function automatic thor_dec_pkg::instr_t r2_word(input logic [5:0] fn);
		thor_dec_pkg::instr_t w;
		w = op_word(`THOR_OP_R2);
		w[`THOR_F_FUNC] = fn;
		return w;
	endfunction

	task automatic apply_reset();
		int n;
		arst_n = 1'b0;
		for (n = 0; n < RESET_CYCLES; n++)
			@(posedge clk);
		#2;
		arst_n = 1'b1;
	endtask

	// One instruction in, then wait for its result with a bound
	task automatic issue(input thor_dec_pkg::instr_t i_ir, input thor_dec_pkg::instr_t i_xir,
		input logic i_xval);
		int cycles;
		ir = i_ir;
		xir = i_xir;
		xval = i_xval;
		in_valid = 1'b1;
		step();
		in_valid = 1'b0;
		cycles = 1;
		while (!out_valid && cycles < TIMEOUT)
		begin
			step();
			cycles++;
		end
		if (!out_valid)
		begin
			$display("timeout: out_valid did not rise within %0d cycles", TIMEOUT);
			stop_run();
		end
		check("latency", 1, cycles);
	endtask

	// ===============================================
	// Tests
	// ===============================================
	task automatic test_valid_timing();
		thor_dec_pkg::instr_t a, b;
		test_name = "valid_timing";
		check("reset out_valid", 0, out_valid);
		check("reset imm", 0, imm);
		check("reset jmptgt", 0, jmptgt);
		check("reset ra", 0, ra);
		check("reset memsz", 0, memsz);
		check("reset lk_sel", 0, lk_sel);
		a = r2_word(`THOR_FN_ADD);
		b = r2_word(`THOR_FN_ADD);
		b[`THOR_F_RB] = ~a[`THOR_F_RB];
		issue(b, '0, 1'b0);
		check("single rb", b[`THOR_F_RB], rb);
		// Back-to-back pair then a gap
		ir = a;
		in_valid = 1'b1;
		step();
		check("first valid", 1, out_valid);
		check("first rb", a[`THOR_F_RB], rb);
		ir = b;
		step();
		check("second valid", 1, out_valid);
		check("second rb", b[`THOR_F_RB], rb);
		in_valid = 1'b0;
		step();
		check("valid after gap", 0, out_valid);
		check("held rb", b[`THOR_F_RB], rb);
	endtask

	task automatic test_regs();
		thor_dec_pkg::instr_t w;
		test_name = "regs";
		w = r2_word(`THOR_FN_ADD);
		issue(w, '0, 1'b0);
		check("add ra", w[`THOR_F_RA], ra);
		check("add rb", w[`THOR_F_RB], rb);
		check("add rc", w[`THOR_F_RC], rc);
		check("add rt", w[`THOR_F_RT], rt);
		check("add rfwr", 1, rfwr);
		w = op_word(`THOR_OP_STO);
		// Nonzero source so a zero Rt stands out
		w[`THOR_F_RS] = w[`THOR_F_RS] | 5'd1;
		issue(w, '0, 1'b0);
		check("store rt", 0, rt);
		check("store rc", w[`THOR_F_RS], rc);
		check("store rfwr", 0, rfwr);
		w = op_word(`THOR_OP_DJMP);
		w[`THOR_F_RA] = ~`THOR_DJMP_REG;
		w[`THOR_F_RT] = ~`THOR_DJMP_REG;
		issue(w, '0, 1'b0);
		check("djmp ra", 26, ra);
		check("djmp rt", 26, rt);
		check("djmp rfwr", 1, rfwr);
		check("djmp dj", 1, dj);
		check("djmp jmp", 1, jmp);
	endtask

	task automatic test_imm();
		thor_dec_pkg::instr_t w, x;
		logic [63:0] base, exp;
		test_name = "imm";
		w = op_word(`THOR_OP_ADDI);
		issue(w, '0, 1'b0);
		check("addi", sext(w[`THOR_F_SIMM], 13), imm);
		w = op_word(`THOR_OP_ANDI);
		issue(w, '0, 1'b0);
		check("andi", {{51{1'b1}}, w[`THOR_F_SIMM]}, imm);
		w = op_word(`THOR_OP_ORI);
		issue(w, '0, 1'b0);
		check("ori", {51'd0, w[`THOR_F_SIMM]}, imm);
		w = op_word(`THOR_OP_ADDIL);
		issue(w, '0, 1'b0);
		check("addil", sext(w[`THOR_F_LIMM], 29), imm);
		w = op_word(`THOR_OP_LDBX);
		issue(w, '0, 1'b0);
		check("indexed load", 0, imm);
		// EXI24 payload lands above bit 23
		w = op_word(`THOR_OP_ADDI);
		x = op_word(`THOR_OP_EXI24);
		base = sext(w[`THOR_F_SIMM], 13);
		exp = sext(x[`THOR_F_X24], 24) << 24;
		exp[23:0] = base[23:0];
		issue(w, x, 1'b1);
		check("exi24 merge", exp, imm);
		issue(w, x, 1'b0);
		check("exi24 ignored", base, imm);
	endtask

	task automatic test_class();
		test_name = "class";
		issue(op_word(`THOR_OP_LDBU), '0, 1'b0);
		check("ldbu flags", 3'b110, {ld, ldz, st});
		check("ldbu size", `THOR_SZ_BYTE, memsz);
		check("ldbu multi", 1, multi_cycle);
		issue(op_word(`THOR_OP_STW), '0, 1'b0);
		check("stw flags", 3'b001, {ld, ldz, st});
		check("stw size", `THOR_SZ_WYDE, memsz);
		issue(op_word(`THOR_OP_LDOX), '0, 1'b0);
		check("ldox ld", 1, ld);
		check("ldox size", `THOR_SZ_OCTA, memsz);
		issue(r2_word(`THOR_FN_MULU), '0, 1'b0);
		check("mulu flags", 8'b0100_0010, {mul, mulu, muli, div, divu, divi, mulall, divall});
		check("mulu multi", 1, multi_cycle);
		issue(op_word(`THOR_OP_DIVI), '0, 1'b0);
		check("divi flags", 8'b0000_0101, {mul, mulu, muli, div, divu, divi, mulall, divall});
		check("divi multi", 1, multi_cycle);
		issue(r2_word(`THOR_FN_ADD), '0, 1'b0);
		check("add none", 0, {ld, ldz, st, mul, mulu, muli, div, divu, divi,
			mulall, divall, multi_cycle});
	endtask

	task automatic test_flow();
		thor_dec_pkg::instr_t w;
		int i;
		test_name = "flow";
		// Sweep all link numbers so both write cases occur
		for (i = 0; i < 4; i++)
		begin
			w = op_word(`THOR_OP_JEQ);
			w[`THOR_F_LK] = i[1:0];
			issue(w, '0, 1'b0);
			check("jeq is_jxx", 1, is_jxx);
			check("jeq flowchg", 1, flowchg);
			check("jeq target", sext(w[`THOR_F_BTGT], 24) << 1, jmptgt);
			check("jeq lk_rd", w[`THOR_F_LKRD], lk_rd);
			check("jeq lk_sel", i, lk_sel);
			check("jeq lk_wr", (i != 0), lk_wr);
		end
		w = op_word(`THOR_OP_JMP);
		issue(w, '0, 1'b0);
		check("jmp flag", 1, jmp);
		check("jmp dj", 0, dj);
		check("jmp target", sext(w[`THOR_F_JTGT], 34) << 1, jmptgt);
		check("jmp lk_rd", w[`THOR_F_LKRD], lk_rd);
		w = op_word(`THOR_OP_RTS);
		issue(w, '0, 1'b0);
		check("rts flags", 2'b11, {rts, flowchg});
		check("rts target", sext(w[`THOR_F_JTGT], 34) << 1, jmptgt);
		check("rts lk_rd", w[`THOR_F_LK], lk_rd);
		issue(op_word(`THOR_OP_BRK), '0, 1'b0);
		check("brk lk_sel", 8, lk_sel);
		check("brk lk_wr", 1, lk_wr);
	endtask

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		in_valid = 1'b0;
		ir = '0;
		xir = '0;
		xval = 1'b0;
		seed = 32'hac3f_4513;
		test_name = "reset";
		apply_reset();
		test_valid_timing();
		test_regs();
		test_imm();
		test_class();
		test_flow();
		step();
		if (i_dut.i_sva.fail_count != 0)
		begin
			$display("%0d assertion failures in the bound checker", i_dut.i_sva.fail_count);
			stop_run();
		end
		else
		begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- thor_dec.f
+incdir+common
common/thor_dec_pkg.sv
decoder/thor_dec_regsel.sv
decoder/thor_dec_imm.sv
decoder/thor_dec_class.sv
decoder/thor_dec_flow.sv
design/thor_dec_stage.sv
sim/thor_dec_sva.sv
sim/thor_dec_tb.sv

//--- Bender.yml
package:
  name: thor_dec

sources:
  - include_dirs:
      - common
    files:
      - common/thor_dec_pkg.sv
      - decoder/thor_dec_regsel.sv
      - decoder/thor_dec_imm.sv
      - decoder/thor_dec_class.sv
      - decoder/thor_dec_flow.sv
      - design/thor_dec_stage.sv

  - target: test
    include_dirs:
      - common
    files:
      - sim/thor_dec_sva.sv
      - sim/thor_dec_tb.sv

export_include_dirs:
  - common
